// File: key_recorder.f
source/key_recorder_pkg.sv
source/button_debounce.sv
source/volume_control.sv
source/key_memory.sv
source/record_control.sv
source/codec_command_seq.sv
source/key_recorder_top.sv
tests/key_recorder_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= key_recorder_tb
FILELIST ?= key_recorder.f
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS ?= --binary --timing --assert
OBJ_DIR ?= obj_dir
LOG ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tests/key_recorder_tb.sv
module key_recorder_tb
  import key_recorder_pkg::*;
();

  localparam int addr_width = 6;
  localparam int depth = 1 << addr_width;
  localparam int strobe_period = 10;
  localparam int button_record = 0;
  localparam int button_playback = 1;
  localparam int button_up = 2;
  localparam int button_down = 3;

  logic clock;
  logic reset;
  logic ready;
  logic record_button;
  logic playback_button;
  logic volume_up_button;
  logic volume_down_button;
  key_pattern_t key_pattern;
  key_pattern_t key_out;
  record_mode_t mode;
  volume_t volume;
  codec_command_t codec_command;
  logic command_valid;

  int cycle;
  int strobes;
  int checks;
  int mismatches;
  int timeouts;
  int playback_strobes;

  // reference model state
  volume_t model_volume;
  logic volume_busy;
  int model_step;
  codec_command_t exp_cmd;
  logic exp_cmd_exact;
  record_mode_t model_mode;
  key_pattern_t recorded[$];
  int next_read;
  key_pattern_t exp_key;
  logic record_req;
  int record_at;
  logic play_req;
  int play_at;

  key_recorder_top #(.debounce_count(16), .addr_width(addr_width)) uut (
    .clock(clock), .reset(reset), .ready(ready),
    .record_button(record_button), .playback_button(playback_button),
    .volume_up_button(volume_up_button), .volume_down_button(volume_down_button),
    .key_pattern(key_pattern), .key_out(key_out), .mode(mode), .volume(volume),
    .codec_command(codec_command), .command_valid(command_valid)
  );

  always #4 clock = ~clock;

  ////////////////////////////////////////////////////////////////////////////
  // checking and reporting
  ////////////////////////////////////////////////////////////////////////////

  task automatic compare_values(input logic [31:0] actual, input logic [31:0] expected,
                                input string what);
    checks++;
    if (actual !== expected) begin
      mismatches++;
      $display("mismatch at %0t: %s is %h, expected %h", $time, what, actual, expected);
    end
  endtask

  task automatic finish_report;
    $display("checks %0d, mismatches %0d, timeouts %0d", checks, mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    $display("error at %0t: timed out %s", $time, what);
  endtask

  // codec table as written in the register map
  function automatic codec_command_t command_for(input int step, input volume_t vol);
    codec_command_t cmd;
    logic [4:0] att;
    att = 5'd31 - vol;
    case (step)
      3: cmd = {8'h04, 3'b000, att, 3'b000, att};
      5: cmd = {8'h18, 16'h0808};
      // mic source is code zero on both channels
      6: cmd = {8'h1A, 16'h0000};
      7: cmd = {8'h1C, 16'h0F0F};
      9: cmd = {8'h0E, 16'h8048};
      10: cmd = {8'h0A, 16'h0000};
      11: cmd = {8'h20, 16'h8000};
      default: cmd = {8'h80, 16'h0000};
    endcase
    return cmd;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // model of one strobe
  ////////////////////////////////////////////////////////////////////////////

  task automatic advance_record_model(input key_pattern_t key);
    logic rec;
    logic play;
    // debounce plus edge detect lands well inside 20 cycles
    rec = record_req && cycle >= record_at;
    play = play_req && cycle >= play_at;
    if (rec)
      record_req = 1'b0;
    if (play)
      play_req = 1'b0;
    exp_key = key;
    case (model_mode)
      mode_idle: begin
        if (rec) begin
          model_mode = mode_record;
          recorded.delete();
        end else if (play && recorded.size() > 0) begin
          model_mode = mode_playback;
          exp_key = recorded[0];
          next_read = 1;
        end
      end
      mode_record: begin
        if (rec) begin
          model_mode = mode_idle;
        end else begin
          recorded.push_back(key);
          if (recorded.size() == depth)
            model_mode = mode_idle;
        end
      end
      default: begin
        // record presses are ignored here
        if (next_read == recorded.size()) begin
          model_mode = mode_idle;
        end else begin
          exp_key = recorded[next_read];
          next_read++;
        end
      end
    endcase
  endtask

  // results of the previous strobe just before the next one
  task automatic check_strobe_results;
    if (strobes > 0) begin
      compare_values(32'(command_valid), 32'd1, "command_valid");
      if (exp_cmd_exact)
        compare_values(32'(codec_command), 32'(exp_cmd), "codec_command");
      else
        compare_values(32'(codec_command.addr), 32'(exp_cmd.addr), "codec_command address");
      compare_values(32'(mode), 32'(model_mode), "mode");
      compare_values(32'(key_out), 32'(exp_key), "key_out");
      if (mode == mode_playback)
        playback_strobes++;
    end
  endtask

  task automatic apply_strobe;
    key_pattern_t key;
    key = key_pattern_t'($urandom);
    key_pattern = key;
    exp_cmd = command_for(model_step, model_volume);
    // headphone data is unknown while a volume press settles
    exp_cmd_exact = !volume_busy || model_step != 3;
    model_step = (model_step + 1) % 16;
    strobes++;
    advance_record_model(key);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  // inputs change on the falling edge only
  task automatic tick;
    @(negedge clock);
    cycle++;
    if (cycle % strobe_period == 0) begin
      check_strobe_results();
      apply_strobe();
      ready = 1'b1;
    end else begin
      ready = 1'b0;
    end
  endtask

  task automatic set_button(input int button_id, input logic level);
    case (button_id)
      button_record: record_button = level;
      button_playback: playback_button = level;
      button_up: volume_up_button = level;
      default: volume_down_button = level;
    endcase
  endtask

  task automatic press_button(input int button_id);
    int guard;
    guard = 0;
    // start mid interval so the request hits a known strobe
    while (cycle % strobe_period != 5 && guard < 2 * strobe_period) begin
      tick();
      guard++;
    end
    if (cycle % strobe_period != 5)
      report_timeout("lining a button press up with the strobes");
    set_button(button_id, 1'b1);
    if (button_id == button_record) begin
      record_req = 1'b1;
      record_at = cycle + 20;
    end else if (button_id == button_playback) begin
      play_req = 1'b1;
      play_at = cycle + 20;
    end else begin
      volume_busy = 1'b1;
    end
    repeat (25) tick();
    if (button_id == button_up && model_volume != 5'd31)
      model_volume = model_volume + 1'b1;
    if (button_id == button_down && model_volume != 5'd0)
      model_volume = model_volume - 1'b1;
    volume_busy = 1'b0;
    compare_values(32'(volume), 32'(model_volume), "volume");
    repeat (15) tick();
    set_button(button_id, 1'b0);
    repeat (40) tick();
  endtask

  task automatic wait_strobes(input int n);
    int target;
    int count;
    target = strobes + n;
    count = 0;
    while (strobes < target && count < n * strobe_period + 20) begin
      tick();
      count++;
    end
    if (strobes < target)
      report_timeout("waiting for sample strobes");
  endtask

  task automatic wait_for_mode(input record_mode_t target, input int limit, input string what);
    int count;
    count = 0;
    while (mode != target && count < limit) begin
      tick();
      count++;
    end
    if (mode != target)
      report_timeout(what);
  endtask

  initial begin
    void'($urandom(32'h0019bfb5));
    clock = 1'b0;
    reset = 1'b1;
    ready = 1'b0;
    record_button = 1'b0;
    playback_button = 1'b0;
    volume_up_button = 1'b0;
    volume_down_button = 1'b0;
    key_pattern = '0;
    cycle = 0;
    strobes = 0;
    checks = 0;
    mismatches = 0;
    timeouts = 0;
    playback_strobes = 0;
    model_volume = 5'd8;
    volume_busy = 1'b0;
    model_step = 0;
    exp_cmd = '0;
    exp_cmd_exact = 1'b1;
    model_mode = mode_idle;
    next_read = 0;
    exp_key = '0;
    record_req = 1'b0;
    record_at = 0;
    play_req = 1'b0;
    play_at = 0;
    repeat (2) @(negedge clock);
    reset = 1'b0;

    // state straight out of reset
    compare_values(32'(codec_command), 32'd0, "codec_command after reset");
    compare_values(32'(command_valid), 32'd0, "command_valid after reset");
    compare_values(32'(mode), 32'(mode_idle), "mode after reset");
    compare_values(32'(key_out), 32'd0, "key_out after reset");
    compare_values(32'(volume), 32'd8, "volume after reset");
    wait_strobes(4);

    // volume up into the ceiling and down into the floor then random presses
    repeat (25) press_button(button_up);
    repeat (33) press_button(button_down);
    repeat (10) press_button(($urandom % 2 == 0) ? button_up : button_down);

    // short recording ended by a second record press
    press_button(button_record);
    wait_for_mode(mode_record, 200, "for recording to start");
    wait_strobes(3 + int'($urandom % 12));
    press_button(button_record);
    wait_for_mode(mode_idle, 200, "for recording to stop");
    press_button(button_playback);
    wait_for_mode(mode_playback, 200, "for playback to start");
    wait_for_mode(mode_idle, 1000, "for playback to finish");
    wait_strobes(2);

    // recording that fills the memory then a record press during playback
    press_button(button_record);
    wait_for_mode(mode_record, 200, "for the long recording to start");
    wait_for_mode(mode_idle, (depth + 10) * strobe_period, "for a full memory to stop recording");
    playback_strobes = 0;
    press_button(button_playback);
    wait_for_mode(mode_playback, 200, "for full playback to start");
    press_button(button_record);
    wait_for_mode(mode_idle, (depth + 10) * strobe_period, "for full playback to finish");
    wait_strobes(2);
    compare_values(32'(playback_strobes), 32'(depth), "entries played from a full memory");
    finish_report();
  end

endmodule

// File: source/key_recorder_top.sv
module key_recorder_top
  import key_recorder_pkg::*;
#(
  parameter int debounce_count = 270000,
  parameter int addr_width = 10
) (
  input logic clock,
  input logic reset,
  input logic ready,
  input logic record_button,
  input logic playback_button,
  input logic volume_up_button,
  input logic volume_down_button,
  input key_pattern_t key_pattern,
  output key_pattern_t key_out,
  output record_mode_t mode,
  output volume_t volume,
  output codec_command_t codec_command,
  output logic command_valid
);

  logic record_clean;
  logic playback_clean;
  logic volume_up_clean;
  logic volume_down_clean;
  logic mem_write;
  logic [addr_width-1:0] mem_addr;
  key_pattern_t mem_wdata;
  key_pattern_t mem_rdata;

  ////////////////////////////////////////////////////////////////////////////
  // button cleanup
  ////////////////////////////////////////////////////////////////////////////

  button_debounce #(.debounce_count(debounce_count)) record_debounce (
    .clock(clock), .reset(reset), .noisy(record_button), .clean(record_clean)
  );

  button_debounce #(.debounce_count(debounce_count)) playback_debounce (
    .clock(clock), .reset(reset), .noisy(playback_button), .clean(playback_clean)
  );

  button_debounce #(.debounce_count(debounce_count)) volume_up_debounce (
    .clock(clock), .reset(reset), .noisy(volume_up_button), .clean(volume_up_clean)
  );

  button_debounce #(.debounce_count(debounce_count)) volume_down_debounce (
    .clock(clock), .reset(reset), .noisy(volume_down_button), .clean(volume_down_clean)
  );

  ////////////////////////////////////////////////////////////////////////////
  // volume and codec setup
  ////////////////////////////////////////////////////////////////////////////

  volume_control volume_ctrl (
    .clock(clock), .reset(reset), .up(volume_up_clean), .down(volume_down_clean),
    .volume(volume)
  );

  codec_command_seq command_seq (
    .clock(clock), .reset(reset), .ready(ready), .volume(volume),
    .codec_command(codec_command), .command_valid(command_valid)
  );

  ////////////////////////////////////////////////////////////////////////////
  // record and playback
  ////////////////////////////////////////////////////////////////////////////

  record_control #(.addr_width(addr_width)) recorder (
    .clock(clock), .reset(reset), .ready(ready),
    .record_level(record_clean), .playback_level(playback_clean),
    .key_pattern(key_pattern), .mem_rdata(mem_rdata),
    .mem_write(mem_write), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
    .mode(mode), .key_out(key_out)
  );

  key_memory #(.addr_width(addr_width)) pattern_mem (
    .clock(clock), .write(mem_write), .addr(mem_addr),
    .wdata(mem_wdata), .rdata(mem_rdata)
  );

endmodule

// File: source/codec_command_seq.sv
module codec_command_seq
  import key_recorder_pkg::*;
(
  input logic clock,
  input logic reset,
  input logic ready,
  input volume_t volume,
  output codec_command_t codec_command,
  output logic command_valid
);

  logic [$clog2(command_steps)-1:0] step;
  volume_t attenuation;
  codec_command_t table_entry;

  // codec wants attenuation, not gain
  assign attenuation = volume_max - volume;

  // register table, the gaps keep polling the id register
  always_comb begin
    case (step)
      4'd3: begin
        // same attenuation on left and right
        table_entry = '{
          addr: addr_headphone,
          data: {3'b000, attenuation, 3'b000, attenuation}
        };
      end
      4'd5: table_entry = cmd_pcm_volume;
      4'd6: begin
        // mic on both channels
        table_entry = '{
          addr: addr_record_select,
          data: {5'b00000, record_source_mic, 5'b00000, record_source_mic}
        };
      end
      4'd7: table_entry = cmd_record_gain;
      4'd9: table_entry = cmd_mic_gain;
      4'd10: table_entry = cmd_beep_volume;
      4'd11: table_entry = cmd_general;
      default: table_entry = cmd_read_id;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      step <= '0;
      codec_command <= '0;
      command_valid <= 1'b0;
    end else if (ready) begin
      codec_command <= table_entry;
      // valid from the first load onward
      command_valid <= 1'b1;
      // wraps after the last step
      step <= step + 1'b1;
    end
  end

endmodule

// File: source/record_control.sv
module record_control
  import key_recorder_pkg::*;
#(
  parameter int addr_width = 10
) (
  input logic clock,
  input logic reset,
  input logic ready,
  input logic record_level,
  input logic playback_level,
  input key_pattern_t key_pattern,
  input key_pattern_t mem_rdata,
  output logic mem_write,
  output logic [addr_width-1:0] mem_addr,
  output key_pattern_t mem_wdata,
  output record_mode_t mode,
  output key_pattern_t key_out
);

  localparam int depth = 2 ** addr_width;
  // one extra bit so a full memory can be counted
  typedef logic [addr_width:0] position_t;

  position_t position;
  position_t length;
  logic record_prev;
  logic playback_prev;
  logic record_pending;
  logic playback_pending;
  logic record_request;
  logic playback_request;
  logic at_end;
  logic mem_read;
  logic read_pending;
  key_pattern_t live_key;
  key_pattern_t play_key;

  ////////////////////////////////////////////////////////////////////////////
  // button requests
  ////////////////////////////////////////////////////////////////////////////

  // an edge on the strobe cycle itself counts too
  assign record_request = record_pending | (record_level & ~record_prev);
  assign playback_request = playback_pending | (playback_level & ~playback_prev);

  always_ff @(posedge clock) begin
    if (reset) begin
      record_prev <= 1'b0;
      playback_prev <= 1'b0;
      record_pending <= 1'b0;
      playback_pending <= 1'b0;
    end else begin
      record_prev <= record_level;
      playback_prev <= playback_level;
      // every strobe consumes the requests, acted on or dropped
      if (ready) begin
        record_pending <= 1'b0;
        playback_pending <= 1'b0;
      end else begin
        record_pending <= record_request;
        playback_pending <= playback_request;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // memory access
  ////////////////////////////////////////////////////////////////////////////

  assign at_end = (position == length);
  assign mem_addr = position[addr_width-1:0];
  assign mem_wdata = key_pattern;

  always_comb begin
    mem_write = 1'b0;
    mem_read = 1'b0;
    if (ready) begin
      case (mode)
        // playback start reads entry 0 right away, record wins a tie
        mode_idle: mem_read = !record_request && playback_request && length != '0;
        // the stopping strobe writes nothing
        mode_record: mem_write = !record_request;
        mode_playback: mem_read = !at_end;
        default: mem_read = 1'b0;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // mode fsm, moves only on a strobe
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      mode <= mode_idle;
      position <= '0;
      length <= '0;
    end else if (ready) begin
      case (mode)
        mode_idle: begin
          if (record_request) begin
            mode <= mode_record;
            position <= '0;
            length <= '0;
          end else if (mem_read) begin
            mode <= mode_playback;
            position <= position + 1'b1;
          end
        end
        mode_record: begin
          if (record_request) begin
            mode <= mode_idle;
            position <= '0;
          end else begin
            length <= position + 1'b1;
            position <= position + 1'b1;
            // last address written, memory is full
            if (position == position_t'(depth - 1)) begin
              mode <= mode_idle;
              position <= '0;
            end
          end
        end
        mode_playback: begin
          if (at_end) begin
            mode <= mode_idle;
            position <= '0;
          end else begin
            position <= position + 1'b1;
          end
        end
        default: mode <= mode_idle;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // key output
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      live_key <= '0;
      play_key <= '0;
      read_pending <= 1'b0;
    end else begin
      read_pending <= mem_read;
      if (ready)
        live_key <= key_pattern;
      // memory word lands one cycle after its address
      if (read_pending)
        play_key <= mem_rdata;
    end
  end

  assign key_out = (mode == mode_playback) ? play_key : live_key;

  // writes only while recording, on a strobe
  assert property (@(posedge clock) disable iff (reset)
    mem_write |-> ready && mode == mode_record);

  // playback never reads past what was recorded
  assert property (@(posedge clock) disable iff (reset)
    mode == mode_playback |-> position <= length);

endmodule

// File: source/key_memory.sv
module key_memory
  import key_recorder_pkg::*;
#(
  parameter int addr_width = 10
) (
  input logic clock,
  input logic write,
  input logic [addr_width-1:0] addr,
  input key_pattern_t wdata,
  output key_pattern_t rdata
);

  // one key pattern per sample, maps onto block ram
  key_pattern_t mem [2**addr_width];

  always_ff @(posedge clock) begin
    if (write)
      mem[addr] <= wdata;
    // registered read, data one cycle after the address
    rdata <= mem[addr];
  end

endmodule

// File: source/volume_control.sv
module volume_control
  import key_recorder_pkg::*;
(
  input logic clock,
  input logic reset,
  input logic up,
  input logic down,
  output volume_t volume
);

  logic up_prev;
  logic down_prev;
  logic up_edge;
  logic down_edge;

  // rising edges of the clean levels
  assign up_edge = up & ~up_prev;
  assign down_edge = down & ~down_prev;

  always_ff @(posedge clock) begin
    if (reset) begin
      up_prev <= 1'b0;
      down_prev <= 1'b0;
      volume <= volume_reset_value;
    end else begin
      up_prev <= up;
      down_prev <= down;
      // down has priority when both edges land together
      if (down_edge) begin
        if (volume != '0)
          volume <= volume - 1'b1;
      end else if (up_edge && volume != volume_max) begin
        volume <= volume + 1'b1;
      end
    end
  end

  // at most one step per cycle and no wrap at either end
  assert property (@(posedge clock) disable iff (reset)
    !$past(reset) |-> (int'(volume) == int'($past(volume))) ||
                      (int'(volume) == int'($past(volume)) + 1) ||
                      (int'(volume) == int'($past(volume)) - 1));

endmodule

// File: source/button_debounce.sv
module button_debounce #(
  parameter int debounce_count = 270000
) (
  input logic clock,
  input logic reset,
  input logic noisy,
  output logic clean
);

  // counter wide enough to hold the settle limit
  localparam int count_width = $clog2(debounce_count + 1);
  typedef logic [count_width-1:0] count_t;

  count_t count;
  // last level seen on the raw input
  logic held;

  always_ff @(posedge clock) begin
    if (reset) begin
      // follow the raw level straight through while in reset
      count <= '0;
      held <= noisy;
      clean <= noisy;
    end else if (noisy != held) begin
      // input moved, start settling again
      held <= noisy;
      count <= '0;
    end else if (count == count_t'(debounce_count)) begin
      // stable long enough, pass it on
      clean <= held;
    end else begin
      count <= count + 1'b1;
    end
  end

endmodule

// File: source/key_recorder_pkg.sv
package key_recorder_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // data widths
  ////////////////////////////////////////////////////////////////////////////

  // one bit per key, the unit that is recorded and played back
  typedef logic [16:0] key_pattern_t;

  // headphone volume, 31 is loudest
  typedef logic [4:0] volume_t;

  // codec register address and value
  typedef logic [7:0] codec_addr_t;
  typedef logic [15:0] codec_data_t;

  // one codec register access, address in the upper byte
  typedef struct packed {
    codec_addr_t addr;
    codec_data_t data;
  } codec_command_t;

  // record and playback modes
  typedef enum logic [1:0] {
    mode_idle,
    mode_record,
    mode_playback
  } record_mode_t;

  ////////////////////////////////////////////////////////////////////////////
  // constants
  ////////////////////////////////////////////////////////////////////////////

  localparam volume_t volume_reset_value = 5'd8;
  localparam volume_t volume_max = 5'd31;

  // length of the command loop, one step per sample strobe
  localparam int command_steps = 16;

  // record source code for the microphone input
  localparam logic [2:0] record_source_mic = 3'b000;

  // register addresses whose data is built at run time
  localparam codec_addr_t addr_headphone = 8'h04;
  localparam codec_addr_t addr_record_select = 8'h1A;

  // fixed entries of the command table
  localparam codec_command_t cmd_read_id = '{addr: 8'h80, data: 16'h0000};
  localparam codec_command_t cmd_pcm_volume = '{addr: 8'h18, data: 16'h0808};
  localparam codec_command_t cmd_record_gain = '{addr: 8'h1C, data: 16'h0F0F};
  localparam codec_command_t cmd_mic_gain = '{addr: 8'h0E, data: 16'h8048};
  localparam codec_command_t cmd_beep_volume = '{addr: 8'h0A, data: 16'h0000};
  localparam codec_command_t cmd_general = '{addr: 8'h20, data: 16'h8000};

endpackage
